//--- src/dwc_types_pkg.sv
`default_nettype none

package dwc_types_pkg;

    localparam int WIDE_W   = 32;
    localparam int NARROW_W = 8;
    localparam int LANES    = WIDE_W / NARROW_W;  // narrow lanes per wide beat

    typedef logic [WIDE_W-1:0]         wide_data_t;
    typedef logic [LANES-1:0]          wide_keep_t;
    typedef logic [NARROW_W-1:0]       narrow_data_t;
    typedef logic [$clog2(LANES)-1:0]  lane_idx_t;

    // one beat as it enters a channel
    typedef struct packed {
        wide_data_t data;
        wide_keep_t keep;
        logic       last;
    } wide_beat_t;

    // one byte on the narrow side
    typedef struct packed {
        narrow_data_t data;
        logic         keep;
        logic         user;  // channel id, zero until the mux
        logic         last;
    } narrow_beat_t;

endpackage

`default_nettype wire

//--- src/dwc_ctrl_pkg.sv
`default_nettype none

package dwc_ctrl_pkg;

    localparam int NUM_CHAN = 2;

    typedef logic [$clog2(NUM_CHAN)-1:0] chan_id_t;

    // packet arbiter states
    typedef enum logic {
        ARB_IDLE,  // waiting for a request
        ARB_BUSY   // packet in progress
    } arb_state_e;

endpackage

`default_nettype wire

//--- src/axis_reg_slice.sv
`default_nettype none

module axis_reg_slice
    import dwc_types_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,

    input  wire narrow_beat_t s_beat_i,
    input  wire          s_valid_i,
    output logic         s_ready_o,

    output narrow_beat_t m_beat_o,
    output logic         m_valid_o,
    input  wire          m_ready_i
);

    narrow_beat_t main_q;
    narrow_beat_t skid_q;
    logic         main_vld_q;
    logic         skid_vld_q;
    logic         main_load;
    logic         skid_load;

    // main register is free when empty or draining this cycle
    assign main_load = m_ready_i | ~main_vld_q;
    // stalled main, catch the incoming beat in the skid
    assign skid_load = ~main_load & s_valid_i & ~skid_vld_q;

    assign s_ready_o = ~skid_vld_q;  // registered ready
    assign m_valid_o = main_vld_q;
    assign m_beat_o  = main_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            main_vld_q <= 1'b0;
            skid_vld_q <= 1'b0;
        end
        else if (main_load)
        begin
            // skid holds the older beat, so it goes first
            main_vld_q <= skid_vld_q | s_valid_i;
            skid_vld_q <= 1'b0;
        end
        else if (skid_load)
        begin
            skid_vld_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (main_load)
        begin
            if (skid_vld_q)
                main_q <= skid_q;
            else
                main_q <= s_beat_i;
        end
        if (skid_load)
            skid_q <= s_beat_i;
    end

endmodule

`default_nettype wire

//--- src/axis_dw_downsizer.sv
`default_nettype none

module axis_dw_downsizer
    import dwc_types_pkg::*;
#(
    parameter bit KEEP_EN = 1'b1
)
(
    input  wire          clk,
    input  wire          rst_n,

    input  wire wide_beat_t s_beat_i,
    input  wire          s_valid_i,
    output logic         s_ready_o,

    output narrow_beat_t m_beat_o,
    output logic         m_valid_o,
    input  wire          m_ready_i
);

    wide_keep_t eff_keep;   // lanes a fresh beat will send
    wide_keep_t lanes;      // lanes still to send, current one included
    wide_keep_t rest;       // lanes above the current one
    lane_idx_t  cur_lane;
    logic       last_lane;
    logic       m_fire;

    logic       busy_q;     // part of the wide beat already sent
    lane_idx_t  cnt_q;      // lane counter
    wide_keep_t rem_q;      // lane mask left after the sent lanes

    function automatic lane_idx_t lowest_lane(input wide_keep_t mask);
        lane_idx_t idx;
        idx = '0;
        for (int i = LANES - 1; i >= 0; i--)
        begin
            if (mask[i])
                idx = lane_idx_t'(i);
        end
        return idx;
    endfunction

    // without keep support every lane goes out
    assign eff_keep = KEEP_EN ? s_beat_i.keep : '1;

    assign lanes    = busy_q ? rem_q : eff_keep;
    assign cur_lane = busy_q ? cnt_q : lowest_lane(eff_keep);

    always_comb
    begin
        for (int i = 0; i < LANES; i++)
            rest[i] = lanes[i] && (i > int'(cur_lane));
    end

    assign last_lane = ~|rest;

    // an all-empty beat never shows up on the narrow side
    assign m_valid_o = s_valid_i & (|lanes);
    assign m_fire    = m_valid_o & m_ready_i;

    // free the wide beat with its highest kept lane, or at once if empty
    assign s_ready_o = s_valid_i & ((~|lanes) | (last_lane & m_ready_i));

    always_comb
    begin
        m_beat_o.data = s_beat_i.data[cur_lane*NARROW_W +: NARROW_W];
        m_beat_o.keep = s_beat_i.keep[cur_lane];
        m_beat_o.user = 1'b0;  // tagged later by the mux
        m_beat_o.last = s_beat_i.last & last_lane;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            rem_q  <= '0;
        end
        else if (m_fire)
        begin
            if (last_lane)
            begin
                busy_q <= 1'b0;
            end
            else
            begin
                busy_q <= 1'b1;
                rem_q  <= rest;
                cnt_q  <= lowest_lane(rest);  // skip empty lanes
            end
        end
    end

endmodule

`default_nettype wire

//--- src/axis_pkt_mux.sv
`default_nettype none

module axis_pkt_mux
    import dwc_types_pkg::*;
    import dwc_ctrl_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n,

    input  wire narrow_beat_t a_beat_i,
    input  wire          a_valid_i,
    output logic         a_ready_o,

    input  wire narrow_beat_t b_beat_i,
    input  wire          b_valid_i,
    output logic         b_ready_o,

    output narrow_beat_t m_beat_o,
    output logic         m_valid_o,
    input  wire          m_ready_i
);

    narrow_beat_t        in_beat [NUM_CHAN];
    logic [NUM_CHAN-1:0] in_valid;
    logic [NUM_CHAN-1:0] in_ready;

    arb_state_e state_q;
    chan_id_t   last_q;  // granted channel, kept as last served
    chan_id_t   pref;
    chan_id_t   pick;
    logic       m_fire;

    assign in_beat[0] = a_beat_i;
    assign in_beat[1] = b_beat_i;
    assign in_valid   = {b_valid_i, a_valid_i};
    assign a_ready_o  = in_ready[0];
    assign b_ready_o  = in_ready[1];

    // round robin, start after the last served channel
    assign pref = chan_id_t'(last_q + 1'b1);
    assign pick = in_valid[pref] ? pref : chan_id_t'(pref + 1'b1);

    assign m_valid_o = (state_q == ARB_BUSY) & in_valid[last_q];
    assign m_fire    = m_valid_o & m_ready_i;

    always_comb
    begin
        m_beat_o      = in_beat[last_q];
        m_beat_o.user = last_q;
    end

    always_comb
    begin
        for (int i = 0; i < NUM_CHAN; i++)
            in_ready[i] = (state_q == ARB_BUSY) && (last_q == chan_id_t'(i)) && m_ready_i;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ARB_IDLE;
            last_q  <= chan_id_t'(NUM_CHAN - 1);  // channel 0 wins first
        end
        else
        begin
            case (state_q)
                ARB_IDLE:
                begin
                    if (|in_valid)
                    begin
                        state_q <= ARB_BUSY;
                        last_q  <= pick;
                    end
                end
                ARB_BUSY:
                begin
                    if (m_fire && m_beat_o.last)  // whole packet done
                        state_q <= ARB_IDLE;
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/dwc_top.sv
`default_nettype none

module dwc_top
    import dwc_types_pkg::*;
#(
    parameter bit KEEP_EN = 1'b1,
    parameter bit OUT_REG = 1'b1
)
(
    input  wire          clk,
    input  wire          rst_n,

    input  wire wide_beat_t s0_beat_i,
    input  wire          s0_valid_i,
    output logic         s0_ready_o,

    input  wire wide_beat_t s1_beat_i,
    input  wire          s1_valid_i,
    output logic         s1_ready_o,

    output narrow_beat_t m_beat_o,
    output logic         m_valid_o,
    input  wire          m_ready_i
);

    narrow_beat_t n0_beat;
    narrow_beat_t n1_beat;
    narrow_beat_t mux_beat;
    logic         n0_valid;
    logic         n0_ready;
    logic         n1_valid;
    logic         n1_ready;
    logic         mux_valid;
    logic         mux_ready;

    axis_dw_downsizer #(.KEEP_EN(KEEP_EN)) u_dsz0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_beat_i  (s0_beat_i),
        .s_valid_i (s0_valid_i),
        .s_ready_o (s0_ready_o),
        .m_beat_o  (n0_beat),
        .m_valid_o (n0_valid),
        .m_ready_i (n0_ready)
    );

    axis_dw_downsizer #(.KEEP_EN(KEEP_EN)) u_dsz1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .s_beat_i  (s1_beat_i),
        .s_valid_i (s1_valid_i),
        .s_ready_o (s1_ready_o),
        .m_beat_o  (n1_beat),
        .m_valid_o (n1_valid),
        .m_ready_i (n1_ready)
    );

    axis_pkt_mux u_mux (
        .clk       (clk),
        .rst_n     (rst_n),
        .a_beat_i  (n0_beat),
        .a_valid_i (n0_valid),
        .a_ready_o (n0_ready),
        .b_beat_i  (n1_beat),
        .b_valid_i (n1_valid),
        .b_ready_o (n1_ready),
        .m_beat_o  (mux_beat),
        .m_valid_o (mux_valid),
        .m_ready_i (mux_ready)
    );

    generate
        if (OUT_REG)
        begin : g_out_reg
            axis_reg_slice u_slice (
                .clk       (clk),
                .rst_n     (rst_n),
                .s_beat_i  (mux_beat),
                .s_valid_i (mux_valid),
                .s_ready_o (mux_ready),
                .m_beat_o  (m_beat_o),
                .m_valid_o (m_valid_o),
                .m_ready_i (m_ready_i)
            );
        end
        else
        begin : g_out_comb
            assign m_beat_o  = mux_beat;
            assign m_valid_o = mux_valid;
            assign mux_ready = m_ready_i;
        end
    endgenerate

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen
#(
    parameter int HALF_PERIOD = 5
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;  // 10 unit period
    end

endmodule

`default_nettype wire

//--- bench/dwc_top_asserts.sv
`default_nettype none

module dwc_top_asserts
    import dwc_types_pkg::*;
(
    input wire          clk,
    input wire          rst_n,
    input wire wide_beat_t s0_beat_i,
    input wire          s0_valid_i,
    input wire          s0_ready_o,
    input wire wide_beat_t s1_beat_i,
    input wire          s1_valid_i,
    input wire          s1_ready_o,
    input wire narrow_beat_t m_beat_o,
    input wire          m_valid_o,
    input wire          m_ready_i
);

    logic in_pkt_q;  // output packet started and last not yet seen
    logic pkt_user_q;
    int   fail_cnt = 0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_pkt_q   <= 1'b0;
            pkt_user_q <= 1'b0;
        end
        else if (m_valid_o && m_ready_i)
        begin
            in_pkt_q   <= ~m_beat_o.last;
            pkt_user_q <= m_beat_o.user;
        end
    end

    s0_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s0_valid_i && !s0_ready_o |=> s0_valid_i && $stable(s0_beat_i))
        else
        begin
            fail_cnt++;
            $error("s0 beat dropped or changed before ready");
        end

    s1_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid_i && !s1_ready_o |=> s1_valid_i && $stable(s1_beat_i))
        else
        begin
            fail_cnt++;
            $error("s1 beat dropped or changed before ready");
        end

    m_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o))
        else
        begin
            fail_cnt++;
            $error("output beat dropped or changed before ready");
        end

    m_keep: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid_o |-> m_beat_o.keep)
        else
        begin
            fail_cnt++;
            $error("output keep is low");
        end

    m_user: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid_o && in_pkt_q |-> m_beat_o.user == pkt_user_q)
        else
        begin
            fail_cnt++;
            $error("channel id changed inside a packet");
        end

endmodule

bind dwc_top dwc_top_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .s0_beat_i  (s0_beat_i),
    .s0_valid_i (s0_valid_i),
    .s0_ready_o (s0_ready_o),
    .s1_beat_i  (s1_beat_i),
    .s1_valid_i (s1_valid_i),
    .s1_ready_o (s1_ready_o),
    .m_beat_o   (m_beat_o),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i)
);

`default_nettype wire

//--- bench/tb_dwc_top.sv
`default_nettype none

module tb_dwc_top
    import dwc_types_pkg::*;
    import dwc_ctrl_pkg::*;
;

    localparam int WAIT_MAX = 1000;
    localparam int END_MAX  = 5000;

    logic         clk;
    logic         rst_n;
    wide_beat_t   s_beat [2];
    logic         s_valid [2];
    logic         s_ready [2];
    narrow_beat_t m_beat;
    logic         m_valid;
    logic         m_ready;

    wide_beat_t  stim_q [2][$];
    logic [8:0]  exp_q [2][$];  // {last, byte}
    logic        grant_q [$];
    logic [31:0] lfsr_q = 32'h317aad4d;
    int          errors = 0;
    logic        in_pkt = 1'b0;
    logic        served = 1'b1;  // last served channel after reset

    tb_clk_gen u_clk (.clk_o(clk));

    dwc_top #(.KEEP_EN(1'b1), .OUT_REG(1'b1)) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .s0_beat_i  (s_beat[0]),
        .s0_valid_i (s_valid[0]),
        .s0_ready_o (s_ready[0]),
        .s1_beat_i  (s_beat[1]),
        .s1_valid_i (s_valid[1]),
        .s1_ready_o (s_ready[1]),
        .m_beat_o   (m_beat),
        .m_valid_o  (m_valid),
        .m_ready_i  (m_ready)
    );

    // galois form with taps for x^32+x^22+x^2+x+1
    function automatic logic take_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          ch;
        logic [31:0] d;
        logic [31:0] k;
        logic [31:0] l;
        string       line;
        fd = $fopen("bench/dwc_trace.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("could not open the trace file");
            return;
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "I %h %h %h %h", ch, d, k, l) == 4)
                stim_q[ch].push_back('{data: d, keep: k[3:0], last: l[0]});
            else if ($sscanf(line, "E %h %h %h", ch, d, l) == 3)
                exp_q[ch].push_back({l[0], d[7:0]});
        end
        $fclose(fd);
    endtask

    task automatic drive_chan(input int ch);
        wide_beat_t b;
        int         cnt;
        while (stim_q[ch].size() > 0)
        begin
            b = stim_q[ch].pop_front();
            if (take_bit() & take_bit())  // idle gap
            begin
                @(posedge clk);
                #1;
            end
            s_beat[ch]  = b;
            s_valid[ch] = 1'b1;
            cnt = 0;
            @(posedge clk);
            while (!s_ready[ch] && cnt < WAIT_MAX)
            begin
                cnt++;
                @(posedge clk);
            end
            if (cnt >= WAIT_MAX)
            begin
                errors++;
                $display("timeout waiting for ready on input channel %0d", ch);
            end
            #1;
            s_valid[ch] = 1'b0;
        end
    endtask

    // mostly ready output back-pressure
    always @(posedge clk)
    begin
        #1;
        m_ready = take_bit() | take_bit();
    end

    // round robin reference with one entry per grant
    always @(posedge clk)
    begin
        if (rst_n && u_dut.u_mux.state_q == ARB_IDLE && (u_dut.n0_valid | u_dut.n1_valid))
        begin
            if (u_dut.n0_valid && u_dut.n1_valid)
                served = ~served;
            else
                served = u_dut.n1_valid;
            grant_q.push_back(served);
        end
    end

    // output scoreboard
    always @(posedge clk)
    begin
        logic [8:0] e;
        if (rst_n && m_valid && m_ready)
        begin
            if (!in_pkt)
            begin
                if (grant_q.size() == 0)
                begin
                    errors++;
                    $display("packet started without a grant");
                end
                else
                    check_value("m_beat.user", m_beat.user, grant_q.pop_front());
            end
            in_pkt = !m_beat.last;
            if (exp_q[m_beat.user].size() == 0)
            begin
                errors++;
                $display("unexpected output byte on channel %0d", m_beat.user);
            end
            else
            begin
                e = exp_q[m_beat.user].pop_front();
                check_value("m_beat.data", m_beat.data, e[7:0]);
                check_value("m_beat.keep", m_beat.keep, 1'b1);
                check_value("m_beat.last", m_beat.last, e[8]);
            end
        end
    end

    initial
    begin
        int cnt;
        rst_n      = 1'b0;
        m_ready    = 1'b0;
        s_valid[0] = 1'b0;
        s_valid[1] = 1'b0;
        s_beat[0]  = '0;
        s_beat[1]  = '0;
        load_trace();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            drive_chan(0);
            drive_chan(1);
        join_none
        cnt = 0;
        while ((exp_q[0].size() > 0 || exp_q[1].size() > 0) && cnt < END_MAX)
        begin
            cnt++;
            @(posedge clk);
        end
        if (cnt >= END_MAX)
        begin
            errors++;
            $display("timeout waiting for the expected output bytes");
        end
        repeat (20) @(posedge clk);
        check_value("exp_q[0] size", exp_q[0].size(), 0);
        check_value("exp_q[1] size", exp_q[1].size(), 0);
        check_value("grant_q size", grant_q.size(), 0);
        check_value("u_asserts.fail_cnt", u_dut.u_asserts.fail_cnt, 0);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/dwc_trace.txt
# I channel data keep last   (wide input beat, hex)
# E channel byte last        (expected narrow output beat, hex)
I 0 44332211 f 0
I 0 88776655 f 1
I 0 0000bbaa 3 0
I 0 ddcc0000 0 0
I 0 00ff00ee 5 1
I 1 a3a2a1a0 f 0
I 1 00c6c500 6 0
I 1 d0000000 8 1
I 1 12345678 0 0
I 1 0000e1e0 3 1
E 0 11 0
E 0 22 0
E 0 33 0
E 0 44 0
E 0 55 0
E 0 66 0
E 0 77 0
E 0 88 1
E 0 aa 0
E 0 bb 0
E 0 ee 0
E 0 ff 1
E 1 a0 0
E 1 a1 0
E 1 a2 0
E 1 a3 0
E 1 c5 0
E 1 c6 0
E 1 d0 1
E 1 e0 0
E 1 e1 1

//--- tb.f
src/dwc_types_pkg.sv
src/dwc_ctrl_pkg.sv
src/axis_reg_slice.sv
src/axis_dw_downsizer.sv
src/axis_pkt_mux.sv
src/dwc_top.sv
bench/tb_clk_gen.sv
bench/dwc_top_asserts.sv
bench/tb_dwc_top.sv

//--- Makefile
TOP := tb_dwc_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
